// File: bench/pacman_tests.svh
`ifndef PACMAN_TESTS_SVH
`define PACMAN_TESTS_SVH

////////////////////
// Stimulus helpers
////////////////////
// Single clock strobe and then the rest of the frame
task automatic run_frame(input bit go_up, input bit go_down, input bit go_left, input bit go_right);
  @(negedge vga_pix_clk);
  btn_up    = go_up;
  btn_down  = go_down;
  btn_left  = go_left;
  btn_right = go_right;
  frame_stb = 1'b1;
  @(negedge vga_pix_clk);
  frame_stb = 1'b0;
  step_model(go_up, go_down, go_left, go_right);
  // Position and score settle 3 clocks after the strobe
  repeat (4) @(negedge vga_pix_clk);
  compare_value("score", exp_score, int'(score));
  compare_value("game_over", int'(exp_over), int'(game_over));
  repeat (FRAME_GAP - 6) @(negedge vga_pix_clk);
endtask

// Colour shows up two clocks after the beam position
task automatic probe_pixel(input int x, input int y, input bit de);
  int exp_rgb;
  exp_rgb = expected_color(x, y, de);
  @(negedge vga_pix_clk);
  sx              = pacman_pkg::SX_W'(x);
  sy              = pacman_pkg::SY_W'(y);
  display_enabled = de;
  repeat (2) @(negedge vga_pix_clk);
  compare_value($sformatf("pixel (%0d,%0d)", x, y), exp_rgb, int'({r, g, b}));
endtask

task automatic probe_tile(input int col, input int row, input bit de);
  probe_pixel(col * 8 + rand_below(8), row * 8 + rand_below(8), de);
endtask

// Back to back pixels along one scan line
task automatic stream_pixels(input int count);
  int exp_q [$];
  int x0;
  int y;
  x0 = rand_below(224 - count);
  y  = rand_below(288);
  for (int k = 0; k < count + 2; k++) begin
    @(negedge vga_pix_clk);
    if (k >= 2) begin
      compare_value($sformatf("stream pixel %0d", k - 2), exp_q.pop_front(), int'({r, g, b}));
    end
    if (k < count) begin
      sx              = pacman_pkg::SX_W'(x0 + k);
      sy              = pacman_pkg::SY_W'(y);
      display_enabled = 1'b1;
      exp_q.push_back(expected_color(x0 + k, y, 1'b1));
    end
  end
endtask

////////////////////
// Directed tests
////////////////////
task automatic reset_and_draw();
  int pw_col;
  int pw_row;
  test_name = "reset_and_draw";
  compare_value("score", 0, int'(score));
  compare_value("game_over", 0, int'(game_over));
  compare_value("rgb after reset", 0, int'({r, g, b}));
  repeat (200) probe_pixel(rand_below(224), rand_below(288), 1'b1);
  probe_tile(13, 30, 1'b1);
  for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
    probe_tile(gh_col[i], int'(pacman_pkg::GHOST_ROWS[i]), 1'b1);
  end
  // Candy dot in an untouched tile
  probe_pixel(2 * 8 + 3 + rand_below(2), 2 * 8 + 3 + rand_below(2), 1'b1);
  // Corner power cookies on the dot and at the tile edge
  for (int i = 0; i < 4; i++) begin
    pw_col = (i % 2 == 1) ? 26 : 1;
    pw_row = (i >= 2) ? 34 : 1;
    probe_pixel(pw_col * 8 + 2 + rand_below(4), pw_row * 8 + 2 + rand_below(4), 1'b1);
    probe_pixel(pw_col * 8 + 7 * rand_below(2), pw_row * 8 + rand_below(8), 1'b1);
  end
  stream_pixels(64);
endtask

// Walk right to the east wall
task automatic eat_candy_row();
  test_name = "eat_candy_row";
  repeat (RIGHT_FRAMES) run_frame(1'b0, 1'b0, 1'b0, 1'b1);
  compare_value("score after row", 13, int'(score));
  probe_tile(26, 30, 1'b1);
  // Eaten tiles have no dot left
  for (int col = 14; col <= 25; col++) begin
    probe_pixel(col * 8 + 3 + rand_below(2), 30 * 8 + 3 + rand_below(2), 1'b1);
  end
endtask

task automatic eat_power_cookie();
  test_name = "eat_power_cookie";
  repeat (DOWN_FRAMES) run_frame(1'b0, 1'b1, 1'b0, 1'b0);
  compare_value("score after cookie", 21, int'(score));
  probe_tile(26, 34, 1'b1);
  probe_tile(26, 35, 1'b1);
endtask

task automatic wall_and_blank();
  test_name = "wall_and_blank";
  repeat (LEFT_FRAMES) run_frame(1'b0, 1'b0, 1'b1, 1'b0);
  repeat (UP_FRAMES) run_frame(1'b1, 1'b0, 1'b0, 1'b0);
  compare_value("score under bar", 38, int'(score));
  probe_tile(13, 29, 1'b1);
  probe_tile(13, 28, 1'b1);
  // Player and wall go black while blanked
  probe_tile(13, 29, 1'b0);
  probe_tile(13, 28, 1'b0);
  repeat (16) probe_pixel(rand_below(224), rand_below(288), 1'b0);
endtask

task automatic ghost_collision();
  int frozen_score;
  int frozen_col;
  int frozen_row;
  test_name = "ghost_collision";
  repeat (CROSS_FRAMES) run_frame(1'b0, 1'b0, 1'b0, 1'b1);
  // Up the right edge into ghost 3's row
  for (int k = 0; k < CLIMB_FRAMES && pl_row > 23 && !exp_over; k++) begin
    run_frame(1'b1, 1'b0, 1'b0, 1'b0);
  end
  for (int k = 0; k < WAIT_FRAMES && !exp_over; k++) begin
    run_frame(1'b0, 1'b0, 1'b0, 1'b0);
  end
  assert (exp_over) else begin
    errors++;
    $display("Ghost never reached the player within the wait limit");
    $display("Test FAILED");
    $fatal(1, "No collision happened");
  end
  frozen_score = exp_score;
  frozen_col   = pl_col;
  frozen_row   = pl_row;
  repeat (FROZEN_FRAMES) run_frame(1'b0, 1'b0, 1'b1, 1'b0);
  compare_value("score after freeze", frozen_score, int'(score));
  probe_tile(frozen_col, frozen_row, 1'b1);
  probe_tile(frozen_col - 1, frozen_row, 1'b1);
endtask

`endif

// File: bench/tb_pacman_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pacman_game;

  localparam int CLK_HALF     = 4;
  localparam int RESET_CYCLES = 10;
  // Clocks between frame strobes
  localparam int FRAME_GAP    = 16;
  // Frames per test
  localparam int RIGHT_FRAMES  = 15;
  localparam int DOWN_FRAMES   = 5;
  localparam int LEFT_FRAMES   = 13;
  localparam int UP_FRAMES     = 6;
  localparam int CROSS_FRAMES  = 13;
  localparam int CLIMB_FRAMES  = 6;
  // Full bounce of a ghost is 50 steps of 4 frames
  localparam int WAIT_FRAMES   = 220;
  localparam int FROZEN_FRAMES = 4;
  localparam int TOTAL_FRAMES  = RIGHT_FRAMES + DOWN_FRAMES + LEFT_FRAMES + UP_FRAMES +
                                 CROSS_FRAMES + CLIMB_FRAMES + WAIT_FRAMES + FROZEN_FRAMES;

  logic                           vga_pix_clk;
  logic                           rst;
  logic                           frame_stb;
  logic                           display_enabled;
  logic                           btn_up;
  logic                           btn_down;
  logic                           btn_left;
  logic                           btn_right;
  logic [pacman_pkg::SX_W-1:0]    sx;
  logic [pacman_pkg::SY_W-1:0]    sy;
  logic [3:0]                     r;
  logic [3:0]                     g;
  logic [3:0]                     b;
  logic [pacman_pkg::SCORE_W-1:0] score;
  logic                           game_over;

  ////////////////////
  // Reference model state
  ////////////////////
  pacman_pkg::tile_t maze [pacman_pkg::MAP_ROWS][pacman_pkg::MAP_COLS];
  int    pl_col;
  int    pl_row;
  int    gh_col   [pacman_pkg::NUM_GHOSTS];
  bit    gh_right [pacman_pkg::NUM_GHOSTS];
  // Frame strobes since the last ghost step
  int    gh_div;
  int    exp_score;
  bit    exp_over;
  int    seed;
  int    errors;
  string test_name;

  pacman_game u_pacman_game (
    .vga_pix_clk     (vga_pix_clk),
    .rst             (rst),
    .frame_stb       (frame_stb),
    .display_enabled (display_enabled),
    .btn_up          (btn_up),
    .btn_down        (btn_down),
    .btn_left        (btn_left),
    .btn_right       (btn_right),
    .sx              (sx),
    .sy              (sy),
    .r               (r),
    .g               (g),
    .b               (b),
    .score           (score),
    .game_over       (game_over)
  );

  initial begin
    vga_pix_clk = 1'b0;
    forever #CLK_HALF vga_pix_clk = ~vga_pix_clk;
  end

  // Twice the frame budget of all tests
  initial begin
    repeat (TOTAL_FRAMES * FRAME_GAP * 2) @(posedge vga_pix_clk);
    $display("Timeout, the test sequence did not finish in time");
    $display("Test FAILED");
    $fatal(1, "Watchdog expired");
  end

  task automatic compare_value(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      errors++;
      $display("MISMATCH test=%s %s expected=0x%0h actual=0x%0h",
               test_name, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "Stopping at the first wrong value");
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  ////////////////////
  // Maze, player and ghost rules
  ////////////////////
  function automatic void init_model();
    for (int row = 0; row < pacman_pkg::MAP_ROWS; row++) begin
      for (int col = 0; col < pacman_pkg::MAP_COLS; col++) begin
        maze[row][col] = pacman_pkg::maze_tile_at(col, row);
      end
    end
    pl_col = 13;
    pl_row = 30;
    for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
      gh_col[i]   = int'(pacman_pkg::GHOST_START_COLS[i]);
      gh_right[i] = 1'b1;
    end
    gh_div    = 0;
    exp_score = 0;
    exp_over  = 1'b0;
  endfunction

  function automatic bit ghost_on_player();
    for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
      if (gh_col[i] == pl_col && int'(pacman_pkg::GHOST_ROWS[i]) == pl_row) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // One frame strobe with the buttons held
  function automatic void step_model(input bit go_up, input bit go_down,
                                     input bit go_left, input bit go_right);
    int nc;
    int nr;
    bit was_over;
    bit hit_early;
    was_over = exp_over;
    // Ghosts step first, in the strobe cycle
    if (!was_over) begin
      gh_div++;
      if (gh_div == 4) begin
        gh_div = 0;
        for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
          gh_col[i] = gh_right[i] ? gh_col[i] + 1 : gh_col[i] - 1;
          if (gh_col[i] == 1 || gh_col[i] == 26) begin
            gh_right[i] = !gh_right[i];
          end
        end
      end
    end
    hit_early = ghost_on_player();
    nc = pl_col;
    nr = pl_row;
    if (go_up) nr--;
    else if (go_down) nr++;
    else if (go_left) nc--;
    else if (go_right) nc++;
    // A ghost arriving this frame does not stop the move yet
    if (!was_over && maze[nr][nc] != pacman_pkg::TILE_WALL) begin
      if (maze[nr][nc] == pacman_pkg::TILE_CANDY) exp_score += 1;
      if (maze[nr][nc] == pacman_pkg::TILE_POWER) exp_score += 5;
      if (exp_score > 1023) exp_score = 1023;
      maze[nr][nc] = pacman_pkg::TILE_EMPTY;
      pl_col = nc;
      pl_row = nr;
    end
    exp_over = was_over || hit_early || ghost_on_player();
  endfunction

  function automatic int expected_color(input int x, input int y, input bit de);
    int tc;
    int tr;
    int ox;
    int oy;
    tc = x / 8;
    tr = y / 8;
    ox = x % 8;
    oy = y % 8;
    if (!de) return 0;
    if (tc == pl_col && tr == pl_row) return int'(pacman_pkg::COLOR_PLAYER);
    // Lowest ghost number wins
    for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
      if (gh_col[i] == tc && int'(pacman_pkg::GHOST_ROWS[i]) == tr) begin
        return int'(pacman_pkg::GHOST_COLORS[i]);
      end
    end
    case (maze[tr][tc])
      pacman_pkg::TILE_WALL: return int'(pacman_pkg::COLOR_WALL);
      pacman_pkg::TILE_CANDY: begin
        if (ox >= 3 && ox <= 4 && oy >= 3 && oy <= 4) return int'(pacman_pkg::COLOR_CANDY);
      end
      pacman_pkg::TILE_POWER: begin
        if (ox >= 2 && ox <= 5 && oy >= 2 && oy <= 5) return int'(pacman_pkg::COLOR_POWER);
      end
      default: ;
    endcase
    return int'(pacman_pkg::COLOR_BLACK);
  endfunction

`include "pacman_tests.svh"

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    seed            = 17220;
    errors          = 0;
    test_name       = "setup";
    rst             = 1'b1;
    frame_stb       = 1'b0;
    display_enabled = 1'b0;
    btn_up          = 1'b0;
    btn_down        = 1'b0;
    btn_left        = 1'b0;
    btn_right       = 1'b0;
    sx              = '0;
    sy              = '0;
    init_model();
    repeat (RESET_CYCLES) @(negedge vga_pix_clk);
    rst = 1'b0;
    reset_and_draw();
    eat_candy_row();
    eat_power_cookie();
    wall_and_blank();
    ghost_collision();
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_pacman_game -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: tb.f
+incdir+bench
verilog/pacman_pkg.sv
verilog/map_port_if.sv
verilog/tile_map_ram.sv
verilog/pacman_movement.sv
verilog/ghost_patrol.sv
verilog/game_status.sv
verilog/pixel_mixer.sv
verilog/pacman_game.sv
bench/tb_pacman_game.sv

// File: verilog/game_status.sv
`timescale 1ns/1ps
`default_nettype none

module game_status (
  input  logic                                              vga_pix_clk,
  input  logic                                              rst,
  input  logic                                              ate_candy,
  input  logic                                              ate_power,
  input  pacman_pkg::tile_pos_t                             player_pos,
  input  pacman_pkg::tile_pos_t [pacman_pkg::NUM_GHOSTS-1:0] ghost_pos,
  output logic [pacman_pkg::SCORE_W-1:0]                    score,
  output logic                                              game_over
);

  logic [pacman_pkg::SCORE_W-1:0] points;
  // One extra bit to catch the overflow
  logic [pacman_pkg::SCORE_W:0]   score_sum;
  logic                           hit;

  ////////////////////
  // Score
  ////////////////////
  always_comb begin
    points = '0;
    if (ate_power) begin
      points = pacman_pkg::SCORE_W'(pacman_pkg::POWER_POINTS);
    end else if (ate_candy) begin
      points = pacman_pkg::SCORE_W'(pacman_pkg::CANDY_POINTS);
    end
  end

  assign score_sum = {1'b0, score} + {1'b0, points};

  // Saturate at all ones
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      score <= '0;
    end else if (ate_candy || ate_power) begin
      score <= score_sum[pacman_pkg::SCORE_W] ? '1 : score_sum[pacman_pkg::SCORE_W-1:0];
    end
  end

  ////////////////////
  // Collision
  ////////////////////
  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
      if (ghost_pos[i] == player_pos) begin
        hit = 1'b1;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      game_over <= 1'b0;
    end else if (hit) begin
      game_over <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ghost_patrol.sv
`timescale 1ns/1ps
`default_nettype none

module ghost_patrol (
  input  logic                  vga_pix_clk,
  input  logic                  rst,
  input  logic                  frame_stb,
  input  logic                  game_over,
  output pacman_pkg::tile_pos_t [pacman_pkg::NUM_GHOSTS-1:0] ghost_pos
);

  localparam int DIV_W = $clog2(pacman_pkg::GHOST_PERIOD);

  logic [DIV_W-1:0]              div_cnt;
  logic                          step;
  logic [pacman_pkg::COL_W-1:0]  col      [pacman_pkg::NUM_GHOSTS];
  logic [pacman_pkg::COL_W-1:0]  col_next [pacman_pkg::NUM_GHOSTS];
  // One bit per ghost, set when heading right
  logic [pacman_pkg::NUM_GHOSTS-1:0] dir_right;

  ////////////////////
  // Frame divider
  ////////////////////
  // Frozen once the game is over
  assign step = frame_stb && !game_over && (div_cnt == DIV_W'(pacman_pkg::GHOST_PERIOD - 1));

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (frame_stb && !game_over) begin
      div_cnt <= step ? '0 : div_cnt + 1'b1;
    end
  end

  ////////////////////
  // Patrol
  ////////////////////
  always_comb begin
    for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
      col_next[i] = dir_right[i] ? col[i] + 1'b1 : col[i] - 1'b1;
    end
  end

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
        col[i] <= pacman_pkg::GHOST_START_COLS[i];
      end
      dir_right <= '1;
    end else if (step) begin
      for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
        col[i] <= col_next[i];
        // Turn around at either end of the row
        if (col_next[i] == pacman_pkg::GHOST_MIN_COL || col_next[i] == pacman_pkg::GHOST_MAX_COL) begin
          dir_right[i] <= ~dir_right[i];
        end
      end
    end
  end

  // Rows never change
  always_comb begin
    for (int i = 0; i < pacman_pkg::NUM_GHOSTS; i++) begin
      ghost_pos[i].col = col[i];
      ghost_pos[i].row = pacman_pkg::GHOST_ROWS[i];
    end
  end

endmodule

`default_nettype wire

// File: verilog/map_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// Game side port of the tile memory
interface map_port_if;

  logic [pacman_pkg::ADDR_W-1:0] addr;
  logic                          we;
  pacman_pkg::tile_t             wdata;
  // Valid one clock after addr
  pacman_pkg::tile_t             rdata;

  modport ram (
    input  addr,
    input  we,
    input  wdata,
    output rdata
  );

  modport client (
    output addr,
    output we,
    output wdata,
    input  rdata
  );

endinterface

`default_nettype wire

// File: verilog/pacman_game.sv
`timescale 1ns/1ps
`default_nettype none

module pacman_game (
  input  logic                           vga_pix_clk,
  input  logic                           rst,
  input  logic                           frame_stb,
  input  logic                           display_enabled,
  input  logic                           btn_up,
  input  logic                           btn_down,
  input  logic                           btn_left,
  input  logic                           btn_right,
  input  logic [pacman_pkg::SX_W-1:0]    sx,
  input  logic [pacman_pkg::SY_W-1:0]    sy,
  output logic [3:0]                     r,
  output logic [3:0]                     g,
  output logic [3:0]                     b,
  output logic [pacman_pkg::SCORE_W-1:0] score,
  output logic                           game_over
);

  // Beam side memory port
  logic [pacman_pkg::ADDR_W-1:0]                     draw_addr;
  pacman_pkg::tile_t                                 draw_tile;
  // Actors
  pacman_pkg::tile_pos_t                             player_pos;
  pacman_pkg::tile_pos_t [pacman_pkg::NUM_GHOSTS-1:0] ghost_pos;
  logic                                              ate_candy;
  logic                                              ate_power;

  // Game side memory port
  map_port_if u_map_port ();

  ////////////////////
  // Maze memory
  ////////////////////
  tile_map_ram u_tile_map_ram (
    .vga_pix_clk (vga_pix_clk),
    .draw_addr   (draw_addr),
    .draw_tile   (draw_tile),
    .game        (u_map_port.ram)
  );

  ////////////////////
  // Game logic
  ////////////////////
  pacman_movement u_pacman_movement (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .frame_stb   (frame_stb),
    .btn_up      (btn_up),
    .btn_down    (btn_down),
    .btn_left    (btn_left),
    .btn_right   (btn_right),
    .game_over   (game_over),
    .map         (u_map_port.client),
    .player_pos  (player_pos),
    .ate_candy   (ate_candy),
    .ate_power   (ate_power)
  );

  ghost_patrol u_ghost_patrol (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .frame_stb   (frame_stb),
    .game_over   (game_over),
    .ghost_pos   (ghost_pos)
  );

  game_status u_game_status (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .ate_candy   (ate_candy),
    .ate_power   (ate_power),
    .player_pos  (player_pos),
    .ghost_pos   (ghost_pos),
    .score       (score),
    .game_over   (game_over)
  );

  ////////////////////
  // Drawing
  ////////////////////
  pixel_mixer u_pixel_mixer (
    .vga_pix_clk     (vga_pix_clk),
    .rst             (rst),
    .display_enabled (display_enabled),
    .sx              (sx),
    .sy              (sy),
    .draw_addr       (draw_addr),
    .draw_tile       (draw_tile),
    .player_pos      (player_pos),
    .ghost_pos       (ghost_pos),
    .r               (r),
    .g               (g),
    .b               (b)
  );

endmodule

`default_nettype wire

// File: verilog/pacman_movement.sv
`timescale 1ns/1ps
`default_nettype none

module pacman_movement (
  input  logic                  vga_pix_clk,
  input  logic                  rst,
  input  logic                  frame_stb,
  input  logic                  btn_up,
  input  logic                  btn_down,
  input  logic                  btn_left,
  input  logic                  btn_right,
  input  logic                  game_over,
  map_port_if.client            map,
  output pacman_pkg::tile_pos_t player_pos,
  output logic                  ate_candy,
  output logic                  ate_power
);

  typedef enum logic {
    ST_IDLE,
    ST_DECIDE
  } state_t;

  state_t                state;
  // Tile the player wants to enter
  pacman_pkg::tile_pos_t cand_next;
  pacman_pkg::tile_pos_t cand;
  logic                  move_ok;
  logic                  eat_candy;
  logic                  eat_power;

  ////////////////////
  // Candidate tile
  ////////////////////
  // Button priority up, down, left, right
  always_comb begin
    cand_next = player_pos;
    if (btn_up) begin
      cand_next.row = player_pos.row - 1'b1;
    end else if (btn_down) begin
      cand_next.row = player_pos.row + 1'b1;
    end else if (btn_left) begin
      cand_next.col = player_pos.col - 1'b1;
    end else if (btn_right) begin
      cand_next.col = player_pos.col + 1'b1;
    end
  end

  // Held for the decide cycle
  always_ff @(posedge vga_pix_clk) begin
    if (state == ST_IDLE && frame_stb) begin
      cand <= cand_next;
    end
  end

  ////////////////////
  // Decide
  ////////////////////
  // rdata holds the probed tile while in ST_DECIDE
  assign move_ok   = (state == ST_DECIDE) && (map.rdata != pacman_pkg::TILE_WALL) && !game_over;
  assign eat_candy = move_ok && (map.rdata == pacman_pkg::TILE_CANDY);
  assign eat_power = move_ok && (map.rdata == pacman_pkg::TILE_POWER);

  // Probe in idle, clear the eaten tile in decide
  assign map.addr  = (state == ST_DECIDE) ? pacman_pkg::tile_addr(cand)
                                          : pacman_pkg::tile_addr(cand_next);
  assign map.we    = eat_candy || eat_power;
  assign map.wdata = pacman_pkg::TILE_EMPTY;

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      player_pos <= pacman_pkg::PLAYER_START;
      ate_candy  <= 1'b0;
      ate_power  <= 1'b0;
    end else begin
      ate_candy <= eat_candy;
      ate_power <= eat_power;
      case (state)
        ST_IDLE: begin
          if (frame_stb) begin
            state <= ST_DECIDE;
          end
        end
        ST_DECIDE: begin
          state <= ST_IDLE;
          if (move_ok) begin
            player_pos <= cand;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/pacman_pkg.sv
`default_nettype none

package pacman_pkg;

  ////////////////////
  // Maze geometry
  ////////////////////
  localparam int MAP_COLS   = 28;
  localparam int MAP_ROWS   = 36;
  // Row stride is a power of two so the address is {row, col}
  localparam int MAP_STRIDE = 32;
  localparam int MAP_DEPTH  = MAP_ROWS * MAP_STRIDE;
  localparam int TILE_SIZE  = 8;
  localparam int OFS_W      = $clog2(TILE_SIZE);

  // Beam and tile index widths
  localparam int SX_W   = 8;
  localparam int SY_W   = 9;
  localparam int COL_W  = 5;
  localparam int ROW_W  = 6;
  localparam int ADDR_W = 11;

  // Horizontal bar above the player start
  localparam int BAR_ROW       = 28;
  localparam int BAR_COL_FIRST = 6;
  localparam int BAR_COL_LAST  = 21;

  typedef enum logic [1:0] {
    TILE_EMPTY = 2'd0,
    TILE_WALL  = 2'd1,
    TILE_CANDY = 2'd2,
    TILE_POWER = 2'd3
  } tile_t;

  typedef struct packed {
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
  } tile_pos_t;

  ////////////////////
  // Colours, 4 bits each of R G B
  ////////////////////
  typedef logic [11:0] color_t;

  localparam color_t COLOR_BLACK  = 12'h000;
  localparam color_t COLOR_WALL   = 12'h00F;
  localparam color_t COLOR_CANDY  = 12'hFFF;
  localparam color_t COLOR_POWER  = 12'hFA0;
  localparam color_t COLOR_PLAYER = 12'hFF0;

  // Dot shapes inside a tile, pixel offsets in both axes
  localparam logic [OFS_W-1:0] CANDY_LO = 3'd3;
  localparam logic [OFS_W-1:0] CANDY_HI = 3'd4;
  localparam logic [OFS_W-1:0] POWER_LO = 3'd2;
  localparam logic [OFS_W-1:0] POWER_HI = 3'd5;

  ////////////////////
  // Actors
  ////////////////////
  localparam int NUM_GHOSTS = 4;
  // Red, pink, cyan, orange
  localparam color_t GHOST_COLORS [NUM_GHOSTS] = '{12'hF00, 12'hF8F, 12'h0FF, 12'hFB4};
  localparam logic [ROW_W-1:0] GHOST_ROWS [NUM_GHOSTS] = '{6'd5, 6'd11, 6'd17, 6'd23};
  localparam logic [COL_W-1:0] GHOST_START_COLS [NUM_GHOSTS] = '{5'd1, 5'd8, 5'd15, 5'd22};
  // Patrol turning points
  localparam logic [COL_W-1:0] GHOST_MIN_COL = 5'd1;
  localparam logic [COL_W-1:0] GHOST_MAX_COL = 5'd26;
  // Frame strobes per ghost step
  localparam int GHOST_PERIOD = 4;

  localparam tile_pos_t PLAYER_START = '{col: 5'd13, row: 6'd30};

  // Scoring
  localparam int SCORE_W      = 10;
  localparam int CANDY_POINTS = 1;
  localparam int POWER_POINTS = 5;

  // Tile memory word address of a tile
  function automatic logic [ADDR_W-1:0] tile_addr(input tile_pos_t pos);
    return ADDR_W'(pos.row) * ADDR_W'(MAP_STRIDE) + ADDR_W'(pos.col);
  endfunction

  // Initial maze contents, rules applied top to bottom
  function automatic tile_t maze_tile_at(input int col, input int row);
    // Padding columns never show up on screen
    if (col >= MAP_COLS) return TILE_EMPTY;
    // Outer border
    if (col == 0 || col == MAP_COLS - 1 || row == 0 || row == MAP_ROWS - 1) return TILE_WALL;
    if (row == BAR_ROW && col >= BAR_COL_FIRST && col <= BAR_COL_LAST) return TILE_WALL;
    // Power cookies in the four corners
    if ((col == 1 || col == MAP_COLS - 2) && (row == 1 || row == MAP_ROWS - 2)) begin
      return TILE_POWER;
    end
    if (col == int'(PLAYER_START.col) && row == int'(PLAYER_START.row)) return TILE_EMPTY;
    return TILE_CANDY;
  endfunction

endpackage

`default_nettype wire

// File: verilog/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
  input  logic                                              vga_pix_clk,
  input  logic                                              rst,
  input  logic                                              display_enabled,
  input  logic [pacman_pkg::SX_W-1:0]                       sx,
  input  logic [pacman_pkg::SY_W-1:0]                       sy,
  output logic [pacman_pkg::ADDR_W-1:0]                     draw_addr,
  input  pacman_pkg::tile_t                                 draw_tile,
  input  pacman_pkg::tile_pos_t                             player_pos,
  input  pacman_pkg::tile_pos_t [pacman_pkg::NUM_GHOSTS-1:0] ghost_pos,
  output logic [3:0]                                        r,
  output logic [3:0]                                        g,
  output logic [3:0]                                        b
);

  pacman_pkg::tile_pos_t          beam_tile;
  // Stage 1, lines up with draw_tile
  pacman_pkg::tile_pos_t          tile1;
  logic [pacman_pkg::OFS_W-1:0]   ofs_x1;
  logic [pacman_pkg::OFS_W-1:0]   ofs_y1;
  logic                           de1;
  logic                           candy_dot;
  logic                           power_dot;
  pacman_pkg::color_t             pix_color;

  ////////////////////
  // Stage 1
  ////////////////////
  // Upper beam bits are the tile index
  assign beam_tile.col = sx[pacman_pkg::SX_W-1:pacman_pkg::OFS_W];
  assign beam_tile.row = sy[pacman_pkg::SY_W-1:pacman_pkg::OFS_W];
  assign draw_addr     = pacman_pkg::tile_addr(beam_tile);

  always_ff @(posedge vga_pix_clk) begin
    tile1  <= beam_tile;
    ofs_x1 <= sx[pacman_pkg::OFS_W-1:0];
    ofs_y1 <= sy[pacman_pkg::OFS_W-1:0];
  end

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      de1 <= 1'b0;
    end else begin
      de1 <= display_enabled;
    end
  end

  ////////////////////
  // Colour select
  ////////////////////
  assign candy_dot = (ofs_x1 >= pacman_pkg::CANDY_LO) && (ofs_x1 <= pacman_pkg::CANDY_HI) &&
                     (ofs_y1 >= pacman_pkg::CANDY_LO) && (ofs_y1 <= pacman_pkg::CANDY_HI);
  assign power_dot = (ofs_x1 >= pacman_pkg::POWER_LO) && (ofs_x1 <= pacman_pkg::POWER_HI) &&
                     (ofs_y1 >= pacman_pkg::POWER_LO) && (ofs_y1 <= pacman_pkg::POWER_HI);

  always_comb begin
    pix_color = pacman_pkg::COLOR_BLACK;
    // Map layer at the bottom
    case (draw_tile)
      pacman_pkg::TILE_EMPTY: pix_color = pacman_pkg::COLOR_BLACK;
      pacman_pkg::TILE_WALL:  pix_color = pacman_pkg::COLOR_WALL;
      pacman_pkg::TILE_CANDY: if (candy_dot) pix_color = pacman_pkg::COLOR_CANDY;
      pacman_pkg::TILE_POWER: if (power_dot) pix_color = pacman_pkg::COLOR_POWER;
    endcase
    // Ghost 0 ends up on top of the others
    for (int i = pacman_pkg::NUM_GHOSTS - 1; i >= 0; i--) begin
      if (ghost_pos[i] == tile1) begin
        pix_color = pacman_pkg::GHOST_COLORS[i];
      end
    end
    // Player over everything
    if (player_pos == tile1) begin
      pix_color = pacman_pkg::COLOR_PLAYER;
    end
    // Blanking
    if (!de1) begin
      pix_color = pacman_pkg::COLOR_BLACK;
    end
  end

  ////////////////////
  // Stage 2
  ////////////////////
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      {r, g, b} <= '0;
    end else begin
      {r, g, b} <= pix_color;
    end
  end

endmodule

`default_nettype wire

// File: verilog/tile_map_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tile_map_ram (
  input  logic                          vga_pix_clk,
  // Port A, beam side, read only
  input  logic [pacman_pkg::ADDR_W-1:0] draw_addr,
  output pacman_pkg::tile_t             draw_tile,
  // Port B, game side
  map_port_if.ram                       game
);

  pacman_pkg::tile_t mem [pacman_pkg::MAP_DEPTH];

  ////////////////////
  // Maze at time zero
  ////////////////////
  initial begin
    for (int row = 0; row < pacman_pkg::MAP_ROWS; row++) begin
      for (int col = 0; col < pacman_pkg::MAP_STRIDE; col++) begin
        mem[row * pacman_pkg::MAP_STRIDE + col] = pacman_pkg::maze_tile_at(col, row);
      end
    end
  end

  ////////////////////
  // Port A
  ////////////////////
  always_ff @(posedge vga_pix_clk) begin
    draw_tile <= mem[draw_addr];
  end

  ////////////////////
  // Port B
  ////////////////////
  // Only this port writes
  always @(posedge vga_pix_clk) begin
    if (game.we) begin
      mem[game.addr] <= game.wdata;
    end
  end

  // Old tile comes back on a write
  always_ff @(posedge vga_pix_clk) begin
    game.rdata <= mem[game.addr];
  end

endmodule

`default_nettype wire
